/* test/br_stim.txt */
# shadow inst npc opa opb dest rob mask tag pred | taken target wr push pop mispredict
# all hex, shadow 1 issues a dependent branch behind a mispredict, target is the fix target
0 E0000010 1000 0 0 05 01 1 2 1 1 1040 0 0 0 0
0 E0000010 1000 5 0 05 02 1 2 0 0 1000 0 0 0 0
0 E4000010 1000 0 0 05 03 1 2 0 1 1040 0 0 0 1
0 E4000010 1000 8 0 05 04 1 2 0 0 1000 0 0 0 0
0 E81FFFF0 2000 FFFFFFFFFFFFFFF8 0 05 05 1 2 1 1 1FC0 0 0 0 0
0 E8000010 1000 8 0 05 06 1 2 1 0 1000 0 0 0 1
0 EC000010 1000 0 0 05 07 1 2 1 1 1040 0 0 0 0
0 EC000010 1000 5 0 05 08 1 2 0 0 1000 0 0 0 0
0 F0000010 1000 5 0 05 09 2 4 1 1 1040 0 0 0 0
0 F0000010 1000 FFFFFFFFFFFFFFF8 0 05 0a 2 4 0 0 1000 0 0 0 0
0 F4000010 1000 5 0 05 0b 2 4 0 1 1040 0 0 0 1
0 F4000010 1000 0 0 05 0c 2 4 0 0 1000 0 0 0 0
0 F81FFFF0 2000 8 0 05 0d 2 4 1 1 1FC0 0 0 0 0
0 F8000010 1000 FFFFFFFFFFFFFFF8 0 05 0e 2 4 0 0 1000 0 0 0 0
0 FC000010 1000 5 0 05 0f 2 4 1 1 1040 0 0 0 0
0 FC000010 1000 0 0 05 10 2 4 1 0 1000 0 0 0 1
0 68000000 3000 0 4567 0a 11 1 8 1 1 4564 1 0 0 0
0 68004000 3000 0 8002 0b 12 1 8 1 1 8000 1 1 0 0
0 68008000 3000 0 9ABF 1f 13 1 8 1 1 9ABC 0 0 1 0
0 6800C000 3000 0 A001 0c 14 1 8 0 1 A000 1 1 1 1
0 C0000010 3000 0 0 1f 15 1 8 1 1 3040 0 0 0 0
0 D01FFFF0 3000 0 0 0d 16 1 8 1 1 2FC0 1 1 0 0
0 C0000010 3000 0 0 0e 17 1 8 0 1 3040 1 0 0 1
1 E4000010 1000 0 0 05 18 1 2 0 1 1040 0 0 0 1
1 FC000010 4000 0 0 05 38 4 8 1 0 4000 0 0 0 1
0 68004000 5000 0 6000 1f 1a 1 2 1 1 6000 0 1 0 0

/* all.f */
src/br_pkg.sv
src/br_res_if.sv
src/br_exec.sv
src/flush_timer.sv
src/recovery_fsm.sv
src/br_unit_top.sv
test/br_unit_tb.sv

/* run.sh */
#!/bin/sh
# compile and run the branch cluster testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

rm -rf obj_dir

if ! verilator --binary --timing --top-module br_unit_tb -f all.f; then
	echo "verilator build failed"
	exit 1
fi

if ! ./obj_dir/Vbr_unit_tb > "$LOG" 2>&1; then
	cat "$LOG"
	echo "simulation exited with an error"
	exit 1
fi

cat "$LOG"

if grep -qx "sim passed" "$LOG"; then
	exit 0
fi
echo "pass message not found in $LOG"
exit 1

/* test/br_unit_tb.sv */
// branch cluster testbench
module br_unit_tb import br_pkg::*;;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int FLUSH_CYCLES = 3;
	localparam int MAX_LINES    = 64;
	localparam int RST_CYCLES   = 8;

	logic            clk;
	logic            rst;
	logic            start_i;
	br_inst_u        inst_i;
	logic [XLEN-1:0] npc_i;
	logic [XLEN-1:0] opa_i;
	logic [XLEN-1:0] opb_i;
	prf_idx_t        dest_tag_i;
	rob_idx_t        rob_idx_i;
	br_mask_t        br_mask_i;
	br_mask_t        br_tag_i;
	logic            pred_taken_i;
	logic            done_o;
	logic            taken_o;
	logic            wr_en_o;
	prf_idx_t        dest_tag_o;
	rob_idx_t        rob_idx_o;
	br_mask_t        br_mask_o;
	logic [XLEN-1:0] link_o;
	logic            ras_push_o;
	logic            ras_pop_o;
	logic            recovery_o;
	br_mask_t        recovery_tag_o;
	logic [XLEN-1:0] recovery_target_o;
	rob_idx_t        recovery_rob_idx_o;

	// one row per stim line
	logic            s_shadow [MAX_LINES];
	br_inst_u        s_inst   [MAX_LINES];
	logic [XLEN-1:0] s_npc    [MAX_LINES];
	logic [XLEN-1:0] s_opa    [MAX_LINES];
	logic [XLEN-1:0] s_opb    [MAX_LINES];
	prf_idx_t        s_dest   [MAX_LINES];
	rob_idx_t        s_rob    [MAX_LINES];
	br_mask_t        s_mask   [MAX_LINES];
	br_mask_t        s_tag    [MAX_LINES];
	logic            s_pred   [MAX_LINES];
	logic            e_taken  [MAX_LINES];
	logic [XLEN-1:0] e_target [MAX_LINES];
	logic            e_wr     [MAX_LINES];
	logic            e_push   [MAX_LINES];
	logic            e_pop    [MAX_LINES];
	logic            e_mis    [MAX_LINES];

	logic [63:0] f [16];
	string       line;
	int          fd;
	int          num_lines;
	int          gap;
	bit          loaded;

	br_unit_top #(
		.FLUSH_CYCLES(FLUSH_CYCLES)
	) dut (
		.clk(clk), .rst(rst), .start_i(start_i), .inst_i(inst_i), .npc_i(npc_i),
		.opa_i(opa_i), .opb_i(opb_i), .dest_tag_i(dest_tag_i), .rob_idx_i(rob_idx_i),
		.br_mask_i(br_mask_i), .br_tag_i(br_tag_i), .pred_taken_i(pred_taken_i),
		.done_o(done_o), .taken_o(taken_o), .wr_en_o(wr_en_o), .dest_tag_o(dest_tag_o),
		.rob_idx_o(rob_idx_o), .br_mask_o(br_mask_o), .link_o(link_o),
		.ras_push_o(ras_push_o), .ras_pop_o(ras_pop_o), .recovery_o(recovery_o),
		.recovery_tag_o(recovery_tag_o), .recovery_target_o(recovery_target_o),
		.recovery_rob_idx_o(recovery_rob_idx_o)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;   // 20 ns period
	end

	task automatic stop_on_mismatch(input string msg);
		$display("error %0t ns: %s", $time, msg);
		$display("sim failed");
		$fatal(1, "stopping at first mismatch");
	endtask

	task automatic check_bit(input string what, input logic got, input logic exp);
		if (got !== exp)
			stop_on_mismatch($sformatf("%s got %b expected %b", what, got, exp));
	endtask

	task automatic check_addr(input string what, input logic [XLEN-1:0] got,
		input logic [XLEN-1:0] exp);
		if (got !== exp)
			stop_on_mismatch($sformatf("%s got %h expected %h", what, got, exp));
	endtask

	task automatic check_tag(input string what, input prf_idx_t got, input prf_idx_t exp);
		if (got !== exp)
			stop_on_mismatch($sformatf("%s got %h expected %h", what, got, exp));
	endtask

	task automatic check_mask(input string what, input br_mask_t got, input br_mask_t exp);
		if (got !== exp)
			stop_on_mismatch($sformatf("%s got %b expected %b", what, got, exp));
	endtask

	task automatic check_rob(input string what, input rob_idx_t got, input rob_idx_t exp);
		if (got !== exp)
			stop_on_mismatch($sformatf("%s got %h expected %h", what, got, exp));
	endtask

	task automatic load_stim();
		fd = $fopen("test/br_stim.txt", "r");
		if (fd == 0) begin
			$display("could not open the stimulus file test/br_stim.txt");
			$display("sim failed");
			$fatal(1, "no stimulus");
		end
		num_lines = 0;
		while (!$feof(fd) && num_lines < MAX_LINES) begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() < 10 || line[0] == "#")   // column notes and blank lines
				continue;
			if ($sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
				f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
				f[10], f[11], f[12], f[13], f[14], f[15]) != 16) begin
				$display("malformed stimulus line: %s", line);
				$display("sim failed");
				$fatal(1, "bad stimulus");
			end
			s_shadow[num_lines] = f[0][0];
			s_inst[num_lines]   = f[1][31:0];
			s_npc[num_lines]    = f[2];
			s_opa[num_lines]    = f[3];
			s_opb[num_lines]    = f[4];
			s_dest[num_lines]   = f[5][PRF_IDX_W-1:0];
			s_rob[num_lines]    = f[6][ROB_IDX_W:0];
			s_mask[num_lines]   = f[7][BR_MASK_W-1:0];
			s_tag[num_lines]    = f[8][BR_MASK_W-1:0];
			s_pred[num_lines]   = f[9][0];
			e_taken[num_lines]  = f[10][0];
			e_target[num_lines] = f[11];
			e_wr[num_lines]     = f[12][0];
			e_push[num_lines]   = f[13][0];
			e_pop[num_lines]    = f[14][0];
			e_mis[num_lines]    = f[15][0];
			num_lines++;
		end
		$fclose(fd);
	endtask

	task automatic check_recovery(input int i);
		check_bit("recovery_o", recovery_o, 1'b1);
		check_mask("recovery_tag_o", recovery_tag_o, s_tag[i]);
		check_addr("recovery_target_o", recovery_target_o, e_target[i]);
		check_rob("recovery_rob_idx_o", recovery_rob_idx_o, s_rob[i]);
		if (s_shadow[i])
			check_bit("done_o during flush", done_o, 1'b0);   // shadow and late starts dropped
	endtask

	task automatic run_line(input int i);
		start_i      = 1'b1;
		inst_i       = s_inst[i];
		npc_i        = s_npc[i];
		opa_i        = s_opa[i];
		opb_i        = s_opb[i];
		dest_tag_i   = s_dest[i];
		rob_idx_i    = s_rob[i];
		br_mask_i    = s_mask[i];
		br_tag_i     = s_tag[i];
		pred_taken_i = s_pred[i];
		@(posedge clk);
		#1;
		check_bit("done_o", done_o, 1'b1);
		check_bit("taken_o", taken_o, e_taken[i]);
		check_bit("wr_en_o", wr_en_o, e_wr[i]);
		check_bit("ras_push_o", ras_push_o, e_push[i]);
		check_bit("ras_pop_o", ras_pop_o, e_pop[i]);
		check_tag("dest_tag_o", dest_tag_o, s_dest[i]);
		check_rob("rob_idx_o", rob_idx_o, s_rob[i]);
		check_mask("br_mask_o", br_mask_o, s_mask[i]);
		check_addr("link_o", link_o, s_npc[i]);
		check_bit("recovery_o at result", recovery_o, 1'b0);
		#1;
		if (s_shadow[i]) begin
			// dependent branch right behind with start held high
			br_mask_i    = s_tag[i];
			br_tag_i     = s_tag[i] << 1;
			rob_idx_i    = s_rob[i] + 1'b1;
			pred_taken_i = e_taken[i];
		end else begin
			start_i = 1'b0;
		end
		@(posedge clk);
		#1;
		if (e_mis[i]) begin
			check_recovery(i);
			if (s_shadow[i])
				check_mask("shadow br_mask_o", br_mask_o, s_tag[i]);
			repeat (FLUSH_CYCLES - 1) begin
				#1;
				@(posedge clk);
				#1;
				check_recovery(i);
				if (s_shadow[i]) begin
					check_mask("squashed br_mask_o", br_mask_o, '0);
					check_bit("squashed taken_o", taken_o, 1'b0);
				end
			end
			#1;
			@(posedge clk);
			#1;
			check_bit("recovery_o after window", recovery_o, 1'b0);
			check_bit("done_o after window", done_o, 1'b0);
		end else begin
			check_bit("recovery_o on correct prediction", recovery_o, 1'b0);
			check_bit("done_o idle", done_o, 1'b0);
		end
		#1;
		start_i = 1'b0;
	endtask

	initial begin
		loaded       = 1'b0;
		rst          = 1'b1;
		start_i      = 1'b0;
		inst_i       = '0;
		npc_i        = '0;
		opa_i        = '0;
		opb_i        = '0;
		dest_tag_i   = '0;
		rob_idx_i    = '0;
		br_mask_i    = '0;
		br_tag_i     = '0;
		pred_taken_i = 1'b0;
		void'($urandom(32'ha0e87a45));
		load_stim();
		loaded = 1'b1;
		repeat (RST_CYCLES) @(posedge clk);
		#1;
		// values left by the reset itself
		check_bit("done_o after reset", done_o, 1'b0);
		check_bit("wr_en_o after reset", wr_en_o, 1'b0);
		check_bit("ras_push_o after reset", ras_push_o, 1'b0);
		check_bit("ras_pop_o after reset", ras_pop_o, 1'b0);
		check_bit("recovery_o after reset", recovery_o, 1'b0);
		#1 rst = 1'b0;
		for (int i = 0; i < num_lines; i++) begin
			gap = int'($urandom % 3);
			repeat (gap) begin
				@(posedge clk);
				#1;
				check_bit("done_o idle", done_o, 1'b0);
				#1;
			end
			run_line(i);
		end
		$display("sim passed");
		$finish;
	end

	// watchdog sized from the stim length
	initial begin
		wait (loaded);
		repeat (num_lines * (FLUSH_CYCLES + 6) + RST_CYCLES + 2) @(posedge clk);
		$display("timeout waiting for results");
		$display("sim failed");
		$fatal(1, "watchdog expired");
	end

endmodule

/* src/br_unit_top.sv */
// branch execution cluster
module br_unit_top import br_pkg::*; #(
	parameter int FLUSH_CYCLES = 3
) (
	input  logic            clk,
	input  logic            rst,
	input  logic            start_i,
	input  br_inst_u        inst_i,
	input  logic [XLEN-1:0] npc_i,
	input  logic [XLEN-1:0] opa_i,
	input  logic [XLEN-1:0] opb_i,
	input  prf_idx_t        dest_tag_i,
	input  rob_idx_t        rob_idx_i,
	input  br_mask_t        br_mask_i,     // dependencies
	input  br_mask_t        br_tag_i,      // own tag
	input  logic            pred_taken_i,
	output logic            done_o,
	output logic            taken_o,
	output logic            wr_en_o,
	output prf_idx_t        dest_tag_o,
	output rob_idx_t        rob_idx_o,
	output br_mask_t        br_mask_o,
	output logic [XLEN-1:0] link_o,
	output logic            ras_push_o,
	output logic            ras_pop_o,
	output logic            recovery_o,
	output br_mask_t        recovery_tag_o,
	output logic [XLEN-1:0] recovery_target_o,
	output rob_idx_t        recovery_rob_idx_o
);

	br_mask_t fix_mask;

	br_res_if res_bus ();

	br_exec u_exec (
		.clk          (clk),
		.rst          (rst),
		.start_i      (start_i),
		.inst_i       (inst_i),
		.npc_i        (npc_i),
		.opa_i        (opa_i),
		.opb_i        (opb_i),
		.dest_tag_i   (dest_tag_i),
		.rob_idx_i    (rob_idx_i),
		.br_mask_i    (br_mask_i),
		.br_tag_i     (br_tag_i),
		.pred_taken_i (pred_taken_i),
		.recovery_i   (recovery_o),     // fed back from the sequencer
		.fix_mask_i   (fix_mask),
		.done_o       (done_o),
		.taken_o      (taken_o),
		.wr_en_o      (wr_en_o),
		.dest_tag_o   (dest_tag_o),
		.rob_idx_o    (rob_idx_o),
		.br_mask_o    (br_mask_o),
		.link_o       (link_o),
		.ras_push_o   (ras_push_o),
		.ras_pop_o    (ras_pop_o),
		.res          (res_bus.exec)
	);

	recovery_fsm #(
		.FLUSH_CYCLES(FLUSH_CYCLES)
	) u_recovery (
		.clk                (clk),
		.rst                (rst),
		.res                (res_bus.seq),
		.recovery_o         (recovery_o),
		.fix_mask_o         (fix_mask),
		.recovery_tag_o     (recovery_tag_o),
		.recovery_target_o  (recovery_target_o),
		.recovery_rob_idx_o (recovery_rob_idx_o)
	);

endmodule

/* src/recovery_fsm.sv */
// mispredict recovery sequencer
module recovery_fsm import br_pkg::*; #(
	parameter int FLUSH_CYCLES = 3
) (
	input  logic            clk,
	input  logic            rst,
	br_res_if.seq           res,
	output logic            recovery_o,
	output br_mask_t        fix_mask_o,
	output br_mask_t        recovery_tag_o,
	output logic [XLEN-1:0] recovery_target_o,
	output rob_idx_t        recovery_rob_idx_o
);

	typedef enum logic {
		IDLE,
		FLUSH
	} state_e;

	state_e          state;
	state_e          state_nxt;
	logic            start_flush;
	logic            expired;
	br_mask_t        tag_r;
	logic [XLEN-1:0] target_r;
	rob_idx_t        rob_idx_r;

	// later mispredicts are ignored while flushing
	assign start_flush = (state == IDLE) && res.valid && res.mispredict;

	always_comb begin
		state_nxt = state;
		case (state)
			IDLE: begin
				if (start_flush)
					state_nxt = FLUSH;
			end
			FLUSH: begin
				if (expired)
					state_nxt = IDLE;
			end
			default: state_nxt = IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst)
			state <= IDLE;
		else
			state <= state_nxt;
	end

	// held for the whole window
	always_ff @(posedge clk) begin
		if (start_flush) begin
			tag_r     <= res.br_tag;
			target_r  <= res.target;
			rob_idx_r <= res.rob_idx;
		end
	end

	flush_timer #(
		.FLUSH_CYCLES(FLUSH_CYCLES)
	) u_timer (
		.clk       (clk),
		.rst       (rst),
		.load_i    (start_flush),
		.expired_o (expired)
	);

	assign recovery_o         = (state == FLUSH);
	assign fix_mask_o         = tag_r;   // squash anything under the bad branch
	assign recovery_tag_o     = tag_r;
	assign recovery_target_o  = target_r;
	assign recovery_rob_idx_o = rob_idx_r;

endmodule

/* src/flush_timer.sv */
// flush window timer
module flush_timer #(
	parameter int FLUSH_CYCLES = 3
) (
	input  logic clk,
	input  logic rst,
	input  logic load_i,
	output logic expired_o
);

	localparam int CNT_W = $clog2(FLUSH_CYCLES + 1);

	logic [CNT_W-1:0] count;

	// counts down to zero and parks there
	always_ff @(posedge clk) begin
		if (rst)
			count <= '0;
		else if (load_i)
			count <= CNT_W'(FLUSH_CYCLES);   // reload restarts the window
		else if (count != '0)
			count <= count - 1'b1;
	end

	// last cycle of the window
	assign expired_o = (count == CNT_W'(1));

endmodule

/* src/br_exec.sv */
// branch execute stage
module br_exec import br_pkg::*; (
	input  logic            clk,
	input  logic            rst,
	input  logic            start_i,
	input  br_inst_u        inst_i,
	input  logic [XLEN-1:0] npc_i,
	input  logic [XLEN-1:0] opa_i,       // condition operand
	input  logic [XLEN-1:0] opb_i,       // jump base
	input  prf_idx_t        dest_tag_i,
	input  rob_idx_t        rob_idx_i,
	input  br_mask_t        br_mask_i,
	input  br_mask_t        br_tag_i,
	input  logic            pred_taken_i,
	input  logic            recovery_i,
	input  br_mask_t        fix_mask_i,
	output logic            done_o,
	output logic            taken_o,
	output logic            wr_en_o,
	output prf_idx_t        dest_tag_o,
	output rob_idx_t        rob_idx_o,
	output br_mask_t        br_mask_o,
	output logic [XLEN-1:0] link_o,
	output logic            ras_push_o,
	output logic            ras_pop_o,
	br_res_if.exec          res
);

	logic [5:0]      opcode;
	logic [2:0]      func;
	jmp_kind_e       kind;
	logic            br_grp;
	logic            is_jmp;
	logic            is_uncond;
	logic            is_cond;
	logic            cond_hit;
	logic            taken_nxt;
	logic            wr_en_nxt;
	logic            push_nxt;
	logic            pop_nxt;
	logic [XLEN-1:0] disp;
	logic [XLEN-1:0] target_nxt;
	logic [XLEN-1:0] fix_target_nxt;
	logic            squash;
	logic            live;

	logic            done_r;
	logic            wr_en_r;
	logic            push_r;
	logic            pop_r;
	logic            taken_r;
	logic            pred_r;
	logic [XLEN-1:0] target_r;
	logic [XLEN-1:0] link_r;
	prf_idx_t        dest_r;
	rob_idx_t        rob_r;
	br_mask_t        mask_r;
	br_mask_t        br_tag_r;

	assign opcode = inst_i.br_fmt.opcode;
	assign func   = opcode[2:0];
	assign kind   = inst_i.jmp_fmt.kind;

	// decode, nothing fires on idle cycles
	assign br_grp    = (opcode[5:3] == OP_BR_GRP_LO) || (opcode[5:3] == OP_BR_GRP_HI);
	assign is_jmp    = start_i && (opcode[5:3] == OP_JMP[5:3]);
	assign is_uncond = start_i && ((opcode == OP_BR) || (opcode == OP_BSR));
	assign is_cond   = start_i && br_grp && !is_uncond;

	// condition on register A
	always_comb begin
		case (func[1:0])
			2'b00: cond_hit = ~opa_i[0];                      // low bit clear
			2'b01: cond_hit = (opa_i == '0);
			2'b10: cond_hit = opa_i[XLEN-1];                  // negative
			default: cond_hit = opa_i[XLEN-1] || (opa_i == '0);
		endcase
		if (func[2])
			cond_hit = ~cond_hit;
	end

	assign disp = {{(XLEN-23){inst_i.br_fmt.disp[20]}}, inst_i.br_fmt.disp, 2'b00};

	assign target_nxt     = is_jmp ? {opb_i[XLEN-1:2], 2'b00} : npc_i + disp;
	assign taken_nxt      = is_jmp || is_uncond || (is_cond && cond_hit);
	assign fix_target_nxt = taken_nxt ? target_nxt : npc_i;   // fall through when not taken
	assign wr_en_nxt      = (is_jmp || is_uncond) && (dest_tag_i != ZERO_REG);

	// return stack hints
	assign push_nxt = (is_jmp && ((kind == JSR) || (kind == JSR_CO)))
		|| (is_uncond && (opcode == OP_BSR));
	assign pop_nxt  = is_jmp && ((kind == RET) || (kind == JSR_CO));

	// result depends on the branch being fixed
	assign squash = recovery_i && ((mask_r & fix_mask_i) != '0);

	always_ff @(posedge clk) begin
		if (rst) begin
			done_r  <= 1'b0;
			wr_en_r <= 1'b0;
			push_r  <= 1'b0;
			pop_r   <= 1'b0;
		end else if (recovery_i) begin
			done_r  <= 1'b0;    // issue dropped during flush
			wr_en_r <= 1'b0;
			push_r  <= 1'b0;
			pop_r   <= 1'b0;
		end else begin
			done_r  <= start_i;
			wr_en_r <= wr_en_nxt;
			push_r  <= push_nxt;
			pop_r   <= pop_nxt;
		end
	end

	always_ff @(posedge clk) begin
		if (squash) begin
			taken_r <= 1'b0;
			mask_r  <= '0;
		end else if (!recovery_i) begin
			taken_r  <= taken_nxt;
			pred_r   <= pred_taken_i;
			target_r <= fix_target_nxt;
			link_r   <= npc_i;
			dest_r   <= dest_tag_i;
			rob_r    <= rob_idx_i;
			mask_r   <= br_mask_i;
			br_tag_r <= br_tag_i;
		end
	end

	assign live = ~recovery_i;   // nothing leaves the stage while flushing

	assign done_o     = done_r && live;
	assign wr_en_o    = wr_en_r && live;
	assign ras_push_o = push_r && live;
	assign ras_pop_o  = pop_r && live;
	assign taken_o    = taken_r;
	assign dest_tag_o = dest_r;
	assign rob_idx_o  = rob_r;
	assign br_mask_o  = mask_r;
	assign link_o     = link_r;

	assign res.valid      = done_o;
	assign res.mispredict = done_o && (taken_r != pred_r);
	assign res.taken      = taken_r;
	assign res.target     = target_r;
	assign res.br_tag     = br_tag_r;
	assign res.rob_idx    = rob_r;

endmodule

/* src/br_res_if.sv */
// resolved branch bus
interface br_res_if import br_pkg::*; ();

	logic            valid;        // one cycle per resolved branch
	logic            mispredict;
	logic            taken;
	logic [XLEN-1:0] target;       // correct next fetch address
	br_mask_t        br_tag;
	rob_idx_t        rob_idx;

	modport exec (
		output valid, mispredict, taken, target, br_tag, rob_idx
	);

	modport seq (
		input valid, mispredict, taken, target, br_tag, rob_idx
	);

endinterface

/* src/br_pkg.sv */
// branch cluster shared definitions
package br_pkg;

	localparam int XLEN      = 64;
	localparam int PRF_IDX_W = 6;
	localparam int ROB_IDX_W = 5;
	localparam int BR_MASK_W = 4;

	typedef logic [PRF_IDX_W-1:0] prf_idx_t;
	typedef logic [ROB_IDX_W:0]   rob_idx_t;   // top bit is the wrap bit
	typedef logic [BR_MASK_W-1:0] br_mask_t;   // one bit per in-flight branch

	// hardwired zero register, link writes to it are dropped
	localparam prf_idx_t ZERO_REG = prf_idx_t'(31);

	// opcodes
	localparam logic [5:0] OP_JMP = 6'h1a;        // jump group, kind in jmp_fmt
	localparam logic [5:0] OP_BR  = 6'h30;
	localparam logic [5:0] OP_BSR = 6'h34;

	// conditional branches live in these two opcode groups
	localparam logic [2:0] OP_BR_GRP_LO = 3'b110;
	localparam logic [2:0] OP_BR_GRP_HI = 3'b111;

	typedef enum logic [1:0] {
		JMP    = 2'b00,
		JSR    = 2'b01,
		RET    = 2'b10,
		JSR_CO = 2'b11   // coroutine, pops and pushes
	} jmp_kind_e;

	// branch format, low opcode bits pick the condition
	typedef struct packed {
		logic [5:0]  opcode;
		logic [4:0]  ra;
		logic [20:0] disp;    // word displacement
	} br_fmt_t;

	// jump format
	typedef struct packed {
		logic [5:0]  opcode;
		logic [4:0]  ra;
		logic [4:0]  rb;
		jmp_kind_e   kind;
		logic [13:0] hint;
	} jmp_fmt_t;

	typedef union packed {
		br_fmt_t  br_fmt;
		jmp_fmt_t jmp_fmt;
	} br_inst_u;

endpackage
